/* Bender.yml */
package:
  name: vmicro16

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vmicro16_pkg.sv
      - hdl/vmicro16_instr_mem.sv
      - hdl/vmicro16_decoder.sv
      - hdl/vmicro16_alu.sv
      - hdl/vmicro16_core_ctrl.sv
      - hdl/vmicro16_data_port.sv
      - hdl/vmicro16_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/vmicro16_tb.sv

/* files.f */
+incdir+hdl
hdl/vmicro16_pkg.sv
hdl/vmicro16_instr_mem.sv
hdl/vmicro16_decoder.sv
hdl/vmicro16_alu.sv
hdl/vmicro16_core_ctrl.sv
hdl/vmicro16_data_port.sv
hdl/vmicro16_top.sv
verification/vmicro16_tb.sv

/* hdl/vmicro16_alu.sv */
// Unsigned ALU, no flags
// NOP and BAD both yield zero
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_alu import vmicro16_pkg::*; (
    input  alu_op_e               op,
    input  logic [`VM_DATA_W-1:0] a,
    input  logic [`VM_DATA_W-1:0] b,
    output logic [`VM_DATA_W-1:0] c
);
    always_comb begin
        case (op)
            // Moves and load/store addresses
            ALU_PASS_B: c = b;
            ALU_OR:     c = a | b;
            ALU_XOR:    c = a ^ b;
            ALU_AND:    c = a & b;
            ALU_NOT:    c = ~b;
            ALU_LSHFT:  c = a << b;
            ALU_RSHFT:  c = a >> b;
            ALU_ADD:    c = a + b;
            ALU_SUB:    c = a - b;
            default:    c = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/vmicro16_consts.svh */
// Constants tied to the 16-bit Vmicro16 encoding
// Changing the field positions also needs a new decoder
`ifndef VMICRO16_CONSTS_SVH
`define VMICRO16_CONSTS_SVH

// Widths and depths
`define VM_DATA_W          16
`define VM_INSTR_DEPTH     64
`define VM_INSTR_AW        6
`define VM_SCRATCH_DEPTH   64
`define VM_SCRATCH_AW      6
`define VM_NUM_REGS        8
`define VM_REG_AW          3
`define VM_GPIO_W          8

// Data port map
`define VM_GPIO_ADDR       16'h00A0

// Branch condition in imm8
`define VM_BR_UNCOND       0

// ARITH_U function codes with simm5[4] set
`define VM_FN_ADD          5'd31
`define VM_FN_SUB          5'd30

// Instruction fields
`define VM_OP_HI           15
`define VM_OP_LO           11
`define VM_RD_HI           10
`define VM_RD_LO           8
`define VM_RA_HI           7
`define VM_RA_LO           5
`define VM_IMM8_HI         7
`define VM_SIMM5_HI        4
`define VM_IMM4_HI         3

`endif

/* hdl/vmicro16_core_ctrl.sv */
// Multi-cycle control: IF R1 R2 [ME] WB, one register read port
// Only the unconditional branch is taken; pc saturates at the last word
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_core_ctrl import vmicro16_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output logic [`VM_INSTR_AW-1:0] fetch_addr,
    input  logic [`VM_DATA_W-1:0]   instr,
    input  decoded_t                dec,
    output logic [`VM_DATA_W-1:0]   instr_word,
    output alu_op_e                 alu_op,
    output logic [`VM_DATA_W-1:0]   a,
    output logic [`VM_DATA_W-1:0]   b,
    input  logic [`VM_DATA_W-1:0]   alu_c,
    output mem_req_t                req,
    input  logic [`VM_DATA_W-1:0]   rdata,
    output logic                    busy
);
    core_state_e           state;
    logic [`VM_INSTR_AW-1:0] pc;
    logic [`VM_DATA_W-1:0] regs [`VM_NUM_REGS];
    logic [`VM_DATA_W-1:0] reg_rd;
    logic [`VM_DATA_W-1:0] b_next;
    logic [`VM_DATA_W-1:0] wb_data;
    logic                  br_taken;
    logic                  stopped;

    assign stopped = (state == ST_IDLE) || (state == ST_HALTED);
    assign busy    = !stopped;

    // Word 0 is already being read when start arrives
    assign fetch_addr = stopped ? '0 : pc;
    assign alu_op     = dec.alu_op;

    // rd in R1, ra otherwise
    assign reg_rd = (state == ST_R1) ? regs[dec.rd] : regs[dec.ra];

    always_comb begin
        if (dec.has_imm8) begin
            b_next = {{(`VM_DATA_W-8){1'b0}}, dec.imm8};
        end else if (dec.has_imm4) begin
            b_next = reg_rd + {{(`VM_DATA_W-4){1'b0}}, dec.imm4};
        end else begin
            b_next = reg_rd;
        end
    end

    assign br_taken = dec.has_br && (dec.imm8 == 8'(`VM_BR_UNCOND));
    assign wb_data  = dec.has_mem ? rdata : alu_c;

    always_comb begin
        req.en    = (state == ST_ME);
        req.we    = (state == ST_ME) && dec.has_mem_we;
        req.addr  = b + {{(`VM_DATA_W-5){dec.simm5[4]}}, dec.simm5};
        req.wdata = a;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            pc         <= '0;
            instr_word <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_HALTED: begin
                    if (start) begin
                        pc    <= '0;
                        state <= ST_IF;
                    end
                end
                ST_IF: begin
                    instr_word <= instr;
                    state      <= ST_R1;
                end
                ST_R1: state <= ST_R2;
                ST_R2: begin
                    // Branch target is reg[rd], latched into a during R1
                    if (br_taken) begin
                        pc <= a[`VM_INSTR_AW-1:0];
                    end else if (pc != '1) begin
                        pc <= pc + 1'b1;
                    end
                    if (dec.halt) begin
                        state <= ST_HALTED;
                    end else if (dec.has_mem) begin
                        state <= ST_ME;
                    end else begin
                        state <= ST_WB;
                    end
                end
                ST_ME: state <= ST_WB;
                ST_WB: state <= ST_IF;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Operand latches
    always_ff @(posedge clk) begin
        if (state == ST_R1) begin
            a <= reg_rd;
        end
        if (state == ST_R2) begin
            b <= b_next;
        end
    end

    // Register file
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VM_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (state == ST_WB && dec.has_we) begin
            regs[dec.rd] <= wb_data;
        end
    end

    // Strobe comes only from a memory instruction's R2 and leads into WB
    a_req_in_me: assert property (@(posedge clk) disable iff (reset)
        req.en |-> ($past(state) == ST_R2 && $past(dec.has_mem)) ##1 state == ST_WB);

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) &&
        state inside {ST_IDLE, ST_IF, ST_R1, ST_R2, ST_ME, ST_WB, ST_HALTED});

endmodule

`default_nettype wire

/* hdl/vmicro16_data_port.sv */
// Scratch memory at 0 to depth-1 and GPIO at VM_GPIO_ADDR, one-cycle read latency
// Unmapped writes are dropped and unmapped reads return 0
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_data_port import vmicro16_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_req_t              req,
    output logic [`VM_DATA_W-1:0] rdata,
    output logic [`VM_GPIO_W-1:0] gpio
);
    logic [`VM_DATA_W-1:0] scratch [`VM_SCRATCH_DEPTH];
    logic                  hit_scratch;
    logic                  hit_gpio;
    logic                  rd_en;

    assign hit_scratch = (req.addr < `VM_SCRATCH_DEPTH);
    assign hit_gpio    = (req.addr == `VM_GPIO_ADDR);
    assign rd_en       = req.en && !req.we;

    always_ff @(posedge clk) begin
        if (req.en && req.we && hit_scratch) begin
            scratch[req.addr[`VM_SCRATCH_AW-1:0]] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio <= '0;
        end else if (req.en && req.we && hit_gpio) begin
            gpio <= req.wdata[`VM_GPIO_W-1:0];
        end
    end

    // Read data held for WB
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (hit_scratch) begin
                rdata <= scratch[req.addr[`VM_SCRATCH_AW-1:0]];
            end else if (hit_gpio) begin
                rdata <= {{(`VM_DATA_W-`VM_GPIO_W){1'b0}}, gpio};
            end else begin
                rdata <= '0;
            end
        end
    end

    // Also catches loads from scratch words never stored
    a_rdata_known: assert property (@(posedge clk) disable iff (reset)
        rd_en && (hit_scratch || hit_gpio) |=> !$isunknown(rdata));

endmodule

`default_nettype wire

/* hdl/vmicro16_decoder.sv */
// Pure combinational decode of one 16-bit instruction
// ADDI maps to ALU_ADD, the imm4 is added into the b operand
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_decoder import vmicro16_pkg::*; (
    input  logic [`VM_DATA_W-1:0] instr,
    output decoded_t              dec
);
    opcode_e opcode;

    assign opcode = opcode_e'(instr[`VM_OP_HI:`VM_OP_LO]);

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_NOP;
        dec.rd     = instr[`VM_RD_HI:`VM_RD_LO];
        dec.ra     = instr[`VM_RA_HI:`VM_RA_LO];
        dec.imm8   = instr[`VM_IMM8_HI:0];
        dec.simm5  = instr[`VM_SIMM5_HI:0];
        dec.imm4   = instr[`VM_IMM4_HI:0];

        case (opcode)
            OP_LW: begin
                dec.alu_op  = ALU_PASS_B;
                dec.has_we  = 1'b1;
                dec.has_mem = 1'b1;
            end
            OP_SW: begin
                dec.alu_op     = ALU_PASS_B;
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            OP_MOV: begin
                dec.alu_op = ALU_PASS_B;
                dec.has_we = 1'b1;
            end
            OP_MOVI: begin
                dec.alu_op   = ALU_PASS_B;
                dec.has_we   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            OP_BR: begin
                dec.has_br   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            OP_BIT: begin
                dec.has_we = 1'b1;
                case (bit_func_e'(instr[`VM_SIMM5_HI:0]))
                    FN_OR:    dec.alu_op = ALU_OR;
                    FN_XOR:   dec.alu_op = ALU_XOR;
                    FN_AND:   dec.alu_op = ALU_AND;
                    FN_NOT:   dec.alu_op = ALU_NOT;
                    FN_LSHFT: dec.alu_op = ALU_LSHFT;
                    FN_RSHFT: dec.alu_op = ALU_RSHFT;
                    default:  dec.alu_op = ALU_BAD;
                endcase
            end
            OP_ARITH_U: begin
                dec.has_we = 1'b1;
                if (instr[`VM_SIMM5_HI]) begin
                    if (instr[`VM_SIMM5_HI:0] == `VM_FN_ADD) begin
                        dec.alu_op = ALU_ADD;
                    end else if (instr[`VM_SIMM5_HI:0] == `VM_FN_SUB) begin
                        dec.alu_op = ALU_SUB;
                    end else begin
                        dec.alu_op = ALU_BAD;
                    end
                end else begin
                    // ADDI
                    dec.alu_op   = ALU_ADD;
                    dec.has_imm4 = 1'b1;
                end
            end
            OP_HALT: dec.halt = 1'b1;
            default: dec.alu_op = ALU_NOP;
        endcase
    end

    // Stores are always memory instructions
    always_comb begin
        a_mem_we_is_mem: assert final (!dec.has_mem_we || dec.has_mem);
    end

endmodule

`default_nettype wire

/* hdl/vmicro16_instr_mem.sv */
// Program memory, loaded only while the core is idle
// A fetch on the same edge as a write to that address returns the old word
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_instr_mem import vmicro16_pkg::*; (
    input  logic                    clk,
    input  prog_wr_t                prog,
    input  logic [`VM_INSTR_AW-1:0] fetch_addr,
    output logic [`VM_DATA_W-1:0]   instr
);
    logic [`VM_DATA_W-1:0] mem [`VM_INSTR_DEPTH];

    // Load port
    always_ff @(posedge clk) begin
        if (prog.en) begin
            mem[prog.addr] <= prog.data;
        end
    end

    // Registered fetch, word valid the cycle after the address
    always_ff @(posedge clk) begin
        instr <= mem[fetch_addr];
    end

    // A loaded word is what a later fetch of that address sees
    a_load_then_fetch: assert property (@(posedge clk)
        prog.en ##1 (!prog.en && fetch_addr == $past(prog.addr))
        |=> instr == $past(prog.data, 2));

endmodule

`default_nettype wire

/* hdl/vmicro16_pkg.sv */
// Types shared by the Vmicro16 core modules
// Opcodes outside opcode_e decode as NOP
`default_nettype none

`include "vmicro16_consts.svh"

package vmicro16_pkg;

    typedef enum logic [4:0] {
        OP_NOP     = 5'd0,
        OP_LW      = 5'd1,
        OP_SW      = 5'd2,
        OP_BIT     = 5'd3,
        OP_ARITH_U = 5'd4,
        OP_MOV     = 5'd5,
        OP_MOVI    = 5'd6,
        OP_BR      = 5'd7,
        OP_HALT    = 5'd31
    } opcode_e;

    // BIT group function codes in simm5
    typedef enum logic [4:0] {
        FN_OR    = 5'd0,
        FN_XOR   = 5'd1,
        FN_AND   = 5'd2,
        FN_NOT   = 5'd3,
        FN_LSHFT = 5'd4,
        FN_RSHFT = 5'd5
    } bit_func_e;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_PASS_B,
        ALU_OR,
        ALU_XOR,
        ALU_AND,
        ALU_NOT,
        ALU_LSHFT,
        ALU_RSHFT,
        ALU_ADD,
        ALU_SUB,
        ALU_BAD
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_IF,
        ST_R1,
        ST_R2,
        ST_ME,
        ST_WB,
        ST_HALTED
    } core_state_e;

    typedef struct packed {
        alu_op_e                alu_op;
        logic [`VM_REG_AW-1:0]  rd;
        logic [`VM_REG_AW-1:0]  ra;
        logic [3:0]             imm4;
        logic [7:0]             imm8;
        logic [4:0]             simm5;
        logic                   has_imm4;
        logic                   has_imm8;
        logic                   has_we;
        logic                   has_br;
        logic                   has_mem;
        logic                   has_mem_we;
        logic                   halt;
    } decoded_t;

    typedef struct packed {
        logic                    en;
        logic [`VM_INSTR_AW-1:0] addr;
        logic [`VM_DATA_W-1:0]   data;
    } prog_wr_t;

    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [`VM_DATA_W-1:0] addr;
        logic [`VM_DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* hdl/vmicro16_top.sv */
// Single Vmicro16 core with local program memory, scratch memory and GPIO
// Load prog only while busy is low
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_top import vmicro16_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  prog_wr_t              prog,
    input  logic                  start,
    output logic                  busy,
    output logic [`VM_GPIO_W-1:0] gpio
);
    logic [`VM_INSTR_AW-1:0] fetch_addr;
    logic [`VM_DATA_W-1:0]   instr;
    logic [`VM_DATA_W-1:0]   instr_word;
    decoded_t                dec;
    alu_op_e                 alu_op;
    logic [`VM_DATA_W-1:0]   a;
    logic [`VM_DATA_W-1:0]   b;
    logic [`VM_DATA_W-1:0]   alu_c;
    mem_req_t                req;
    logic [`VM_DATA_W-1:0]   rdata;

    vmicro16_instr_mem instr_mem_i (
        .clk        (clk),
        .prog       (prog),
        .fetch_addr (fetch_addr),
        .instr      (instr)
    );

    vmicro16_decoder decoder_i (
        .instr (instr_word),
        .dec   (dec)
    );

    vmicro16_core_ctrl core_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .dec        (dec),
        .instr_word (instr_word),
        .alu_op     (alu_op),
        .a          (a),
        .b          (b),
        .alu_c      (alu_c),
        .req        (req),
        .rdata      (rdata),
        .busy       (busy)
    );

    vmicro16_alu alu_i (
        .op (alu_op),
        .a  (a),
        .b  (b),
        .c  (alu_c)
    );

    vmicro16_data_port data_port_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rdata (rdata),
        .gpio  (gpio)
    );

endmodule

`default_nettype wire

/* verification/vmicro16_tb.sv */
// Directed tests for the single Vmicro16 core with each program loaded through prog
// Register r7 holds the GPIO address in every program; registers persist across runs
`default_nettype none
`timescale 1ns/1ns

`include "vmicro16_consts.svh"

module vmicro16_tb import vmicro16_pkg::*; ();

    // 12 programs of at most 64 instructions at 5 cycles each plus margin
    localparam int MAX_CYCLES = 12 * `VM_INSTR_DEPTH * 5 + 1000;
    localparam logic [7:0] GPIO_ADDR8 = 8'(`VM_GPIO_ADDR);

    logic                  clk;
    logic                  reset;
    prog_wr_t              prog;
    logic                  start;
    logic                  busy;
    logic [`VM_GPIO_W-1:0] gpio;

    logic [`VM_DATA_W-1:0] words [$];
    logic [31:0]           rng_state = 32'd83552;
    int                    cycles = 0;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    vmicro16_top vmicro16_top_i (
        .clk   (clk),
        .reset (reset),
        .prog  (prog),
        .start (start),
        .busy  (busy),
        .gpio  (gpio)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_byte(output logic [7:0] v);
        rng_state = xorshift(rng_state);
        v = rng_state[7:0];
    endtask

    // MOVI, BR and HALT format
    function automatic logic [15:0] imm_word(opcode_e op, logic [2:0] rd, logic [7:0] imm8);
        return {op, rd, imm8};
    endfunction

    // Register format with fn in the simm5 field
    function automatic logic [15:0] reg_word(opcode_e op, logic [2:0] rd, logic [2:0] ra,
                                             logic [4:0] fn);
        return {op, rd, ra, fn};
    endfunction

    task automatic emit_gpio_store(logic [2:0] rs);
        words.push_back(imm_word(OP_MOVI, 3'd7, GPIO_ADDR8));
        words.push_back(reg_word(OP_SW, rs, 3'd7, 5'd0));
    endtask

    task automatic emit_halt();
        words.push_back(imm_word(OP_HALT, 3'd0, 8'd0));
    endtask

    task automatic check_gpio(logic [`VM_GPIO_W-1:0] expected, logic [`VM_GPIO_W-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t gpio expected 0x%h got 0x%h", $time, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d wrong check(s)", name, errors - errors_before);
        end
    endtask

    // Load, start, and wait for busy to fall
    task automatic run_program();
        for (int i = 0; i < words.size(); i++) begin
            @(posedge clk);
            prog.en   <= 1'b1;
            prog.addr <= 6'(i);
            prog.data <= words[i];
        end
        @(posedge clk);
        prog.en <= 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_bit("busy", 1'b1, busy);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        check_bit("busy", 1'b0, busy);
        check_gpio(8'h00, gpio);
        finish_test("reset", errors_before);
    endtask

    task automatic test_arith();
        int          errors_before;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  z;
        logic [7:0]  r;
        logic [15:0] expected;
        errors_before = errors;
        next_byte(x);
        next_byte(y);
        next_byte(z);
        next_byte(r);
        // r3 = x, += y, -= z, then ADDI adds r2 + imm4
        expected = {8'h00, x} + {8'h00, y};
        expected = expected - {8'h00, z};
        expected = expected + ({8'h00, y} + {12'h000, r[3:0]});
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd1, x));
        words.push_back(imm_word(OP_MOVI, 3'd2, y));
        words.push_back(imm_word(OP_MOVI, 3'd4, z));
        words.push_back(reg_word(OP_MOV, 3'd3, 3'd1, 5'd0));
        words.push_back(reg_word(OP_ARITH_U, 3'd3, 3'd2, 5'd31));
        words.push_back(reg_word(OP_ARITH_U, 3'd3, 3'd4, 5'd30));
        words.push_back(reg_word(OP_ARITH_U, 3'd3, 3'd2, {1'b0, r[3:0]}));
        emit_gpio_store(3'd3);
        emit_halt();
        run_program();
        check_gpio(expected[7:0], gpio);
        finish_test("arith", errors_before);
    endtask

    task automatic test_bit_op(bit_func_e fn, string name);
        int          errors_before;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] expected;
        errors_before = errors;
        next_byte(x);
        next_byte(y);
        if (fn == FN_LSHFT || fn == FN_RSHFT) begin
            y = {5'b00000, y[2:0]};
        end
        a = {8'h00, x};
        b = {8'h00, y};
        case (fn)
            FN_OR:    expected = a | b;
            FN_XOR:   expected = a ^ b;
            FN_AND:   expected = a & b;
            FN_NOT:   expected = ~b;
            FN_LSHFT: expected = a << b;
            FN_RSHFT: expected = a >> b;
            default:  expected = '0;
        endcase
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd1, x));
        words.push_back(imm_word(OP_MOVI, 3'd2, y));
        words.push_back(reg_word(OP_BIT, 3'd1, 3'd2, fn));
        emit_gpio_store(3'd1);
        emit_halt();
        run_program();
        check_gpio(expected[7:0], gpio);
        finish_test(name, errors_before);
    endtask

    task automatic test_scratch();
        int         errors_before;
        logic [7:0] v;
        errors_before = errors;
        next_byte(v);
        v = v | 8'h01;
        // Base 20 with offset -4 gives scratch word 16
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd1, v));
        words.push_back(imm_word(OP_MOVI, 3'd2, 8'd20));
        words.push_back(reg_word(OP_SW, 3'd1, 3'd2, 5'b11100));
        words.push_back(imm_word(OP_MOVI, 3'd1, ~v));
        // Reload into the overwritten r1
        words.push_back(reg_word(OP_LW, 3'd1, 3'd2, 5'b11100));
        emit_gpio_store(3'd1);
        emit_halt();
        run_program();
        check_gpio(v, gpio);
        // r4 preloaded so a skipped load is visible
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd4, 8'h55));
        words.push_back(imm_word(OP_MOVI, 3'd2, 8'h80));
        words.push_back(reg_word(OP_LW, 3'd4, 3'd2, 5'd0));
        emit_gpio_store(3'd4);
        emit_halt();
        run_program();
        check_gpio(8'h00, gpio);
        finish_test("scratch", errors_before);
    endtask

    task automatic test_branch();
        int         errors_before;
        logic [7:0] good;
        logic [7:0] bad;
        errors_before = errors;
        next_byte(good);
        good = good | 8'h01;
        bad  = ~good;
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd1, good));
        words.push_back(imm_word(OP_MOVI, 3'd2, bad));
        words.push_back(imm_word(OP_MOVI, 3'd5, 8'd7));
        words.push_back(imm_word(OP_BR, 3'd5, 8'd0));
        // 4 to 6 reached only if the taken branch fails
        emit_gpio_store(3'd2);
        emit_halt();
        // Word 7 starts a conditional branch to the bad block at 12
        words.push_back(imm_word(OP_MOVI, 3'd6, 8'd12));
        words.push_back(imm_word(OP_BR, 3'd6, 8'd1));
        emit_gpio_store(3'd1);
        emit_halt();
        emit_gpio_store(3'd2);
        emit_halt();
        run_program();
        check_gpio(good, gpio);
        finish_test("branch", errors_before);
    endtask

    task automatic test_halt_restart();
        int         errors_before;
        logic [7:0] p;
        logic [7:0] q;
        logic [7:0] sum;
        errors_before = errors;
        next_byte(p);
        next_byte(q);
        q   = q | 8'h01;
        sum = p + q;
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd1, p));
        emit_gpio_store(3'd1);
        emit_halt();
        // Never executed
        words.push_back(imm_word(OP_MOVI, 3'd1, q));
        words.push_back(reg_word(OP_SW, 3'd1, 3'd7, 5'd0));
        emit_halt();
        run_program();
        check_gpio(p, gpio);
        repeat (20) begin
            @(negedge clk);
            check_bit("busy", 1'b0, busy);
            check_gpio(p, gpio);
        end
        // Second program relies on r1 and r7 kept from the first
        words.delete();
        words.push_back(imm_word(OP_MOVI, 3'd2, q));
        words.push_back(reg_word(OP_ARITH_U, 3'd2, 3'd1, 5'd31));
        words.push_back(reg_word(OP_SW, 3'd2, 3'd7, 5'd0));
        emit_halt();
        run_program();
        check_gpio(sum, gpio);
        finish_test("halt_restart", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        prog  = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_arith();
        test_bit_op(FN_OR, "bit_or");
        test_bit_op(FN_XOR, "bit_xor");
        test_bit_op(FN_AND, "bit_and");
        test_bit_op(FN_NOT, "bit_not");
        test_bit_op(FN_LSHFT, "bit_lshft");
        test_bit_op(FN_RSHFT, "bit_rshft");
        test_scratch();
        test_branch();
        test_halt_restart();
        $display("%0d tests run, %0d failed, %0d wrong checks", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
